//--- compile.f
+incdir+src
src/openadc_pkg.sv
src/adc_reg_bank.sv
src/adc_level_trigger.sv
src/heartbeat_leds.sv
src/openadc_core.sv
test/openadc_sva.sv
test/openadc_tb.sv

//--- src/adc_level_trigger.sv
`timescale 1ns/1ps
`include "openadc_params.svh"

module adc_level_trigger (
   input  logic                        clk_usb,
   input  logic                        reset,
   input  openadc_pkg::oadc_ctrl_t     ctrl_i,
   input  logic [`OADC_ADC_BITS-1:0]   adc_data_i,
   output openadc_pkg::oadc_status_t   status_o,
   output logic                        trigger_adc_o
);

   logic [`OADC_ADC_BITS-1:0]  test_cnt;
   logic [`OADC_ADC_BITS-1:0]  sample_s1;
   logic [`OADC_ADC_BITS-1:0]  sample_s2;
   logic                       armed_q;
   logic                       armed_r;
   logic                       trig_allowed;
   logic                       trig_seen_q;
   logic                       level_hit;
   logic                       fire;

   // test pattern source
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         test_cnt <= '0;
      end else begin
         test_cnt <= test_cnt + 1'b1;
      end
   end

   always_ff @(posedge clk_usb) begin
      sample_s1 <= ctrl_i.source_adc ? adc_data_i : test_cnt;
      sample_s2 <= sample_s1;
   end

   // level msb set means trigger above, clear means below
   always_comb begin
      if (ctrl_i.trig_level[`OADC_ADC_BITS-1]) begin
         level_hit = sample_s2 > ctrl_i.trig_level;
      end else begin
         level_hit = sample_s2 < ctrl_i.trig_level;
      end
   end

   // blocked while the pulse is out so it stays one cycle wide
   assign fire = trig_allowed && !trigger_adc_o && level_hit;

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         armed_q       <= 1'b0;
         armed_r       <= 1'b0;
         trig_allowed  <= 1'b0;
         trig_seen_q   <= 1'b0;
         trigger_adc_o <= 1'b0;
      end else begin
         armed_r       <= armed_q;
         trigger_adc_o <= fire;
         if (trigger_adc_o) begin   // one shot done, wait for next arm
            armed_q      <= 1'b0;
            trig_allowed <= 1'b0;
            trig_seen_q  <= 1'b1;
         end else begin
            if (ctrl_i.arm_cmd) begin
               armed_q     <= 1'b1;
               trig_seen_q <= 1'b0;
            end
            if (armed_q && !armed_r) begin
               trig_allowed <= 1'b1;
            end
         end
      end
   end

   assign status_o = '{armed: armed_q, trig_seen: trig_seen_q};

endmodule

//--- src/adc_reg_bank.sv
`timescale 1ns/1ps
`include "openadc_params.svh"

module adc_reg_bank (
   input  logic                        clk_usb,
   input  logic                        reset,
   input  openadc_pkg::axil_req_t      axil_req_i,
   input  openadc_pkg::oadc_status_t   status_i,
   output openadc_pkg::axil_rsp_t      axil_rsp_o,
   output openadc_pkg::oadc_ctrl_t     ctrl_o,
   output logic                        amp_gain_o
);

   logic [`OADC_GAIN_BITS-1:0]      gain_q;
   logic [`OADC_LEDSEL_BITS-1:0]    led_sel_q;
   logic [`OADC_ADC_BITS-1:0]       trig_level_q;
   logic                            source_adc_q;
   logic                            arm_q;
   logic                            bvalid_q;
   logic                            rvalid_q;
   logic [`OADC_AXI_DATA_BITS-1:0]  rdata_q;
   logic [`OADC_AXI_DATA_BITS-1:0]  rd_word;
   logic                            wr_hs;
   logic                            rd_hs;
   logic [`OADC_GAIN_BITS:0]        pwm_acc;   // msb is the carry out

   // a pending response holds off the next access
   assign wr_hs = axil_req_i.awvalid && axil_req_i.wvalid && !bvalid_q;
   assign rd_hs = axil_req_i.arvalid && !rvalid_q;

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         gain_q       <= '0;
         led_sel_q    <= '0;
         trig_level_q <= '0;
         source_adc_q <= 1'b0;
         arm_q        <= 1'b0;
      end else begin
         arm_q <= 1'b0;
         if (wr_hs) begin
            case (axil_req_i.awaddr)
               `OADC_REG_GAIN:    gain_q <= axil_req_i.wdata[`OADC_GAIN_BITS-1:0];
               `OADC_REG_LEDSEL:  led_sel_q <= axil_req_i.wdata[`OADC_LEDSEL_BITS-1:0];
               `OADC_REG_TRIGLVL: trig_level_q <= axil_req_i.wdata[`OADC_ADC_BITS-1:0];
               `OADC_REG_CTRL: begin
                  source_adc_q <= axil_req_i.wdata[`OADC_CTRL_SRC_BIT];
                  arm_q        <= axil_req_i.wdata[`OADC_CTRL_ARM_BIT];
               end
               default: ;   // status and holes ignore writes
            endcase
         end
      end
   end

   // write response
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         bvalid_q <= 1'b0;
      end else if (wr_hs) begin
         bvalid_q <= 1'b1;
      end else if (axil_req_i.bready) begin
         bvalid_q <= 1'b0;
      end
   end

   // read mux, unmapped reads give zero
   always_comb begin
      rd_word = '0;
      case (axil_req_i.araddr)
         `OADC_REG_GAIN:    rd_word[`OADC_GAIN_BITS-1:0] = gain_q;
         `OADC_REG_LEDSEL:  rd_word[`OADC_LEDSEL_BITS-1:0] = led_sel_q;
         `OADC_REG_TRIGLVL: rd_word[`OADC_ADC_BITS-1:0] = trig_level_q;
         `OADC_REG_CTRL:    rd_word[`OADC_CTRL_SRC_BIT] = source_adc_q;
         `OADC_REG_STATUS: begin
            rd_word[`OADC_STAT_ARMED_BIT] = status_i.armed;
            rd_word[`OADC_STAT_SEEN_BIT]  = status_i.trig_seen;
         end
         default: ;
      endcase
   end

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         rvalid_q <= 1'b0;
      end else if (rd_hs) begin
         rvalid_q <= 1'b1;
      end else if (axil_req_i.rready) begin
         rvalid_q <= 1'b0;
      end
   end

   // captured once per read, held until rready
   always_ff @(posedge clk_usb) begin
      if (rd_hs) begin
         rdata_q <= rd_word;
      end
   end

   // gain pwm, carry rate is gain/256
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         pwm_acc <= '0;
      end else begin
         pwm_acc <= {1'b0, pwm_acc[`OADC_GAIN_BITS-1:0]} + {1'b0, gain_q};
      end
   end

   assign amp_gain_o = pwm_acc[`OADC_GAIN_BITS];

   always_comb begin
      axil_rsp_o.awready = wr_hs;
      axil_rsp_o.wready  = wr_hs;
      axil_rsp_o.bvalid  = bvalid_q;
      axil_rsp_o.bresp   = `OADC_AXI_RESP_OKAY;
      axil_rsp_o.arready = rd_hs;
      axil_rsp_o.rvalid  = rvalid_q;
      axil_rsp_o.rdata   = rdata_q;
      axil_rsp_o.rresp   = `OADC_AXI_RESP_OKAY;
   end

   always_comb begin
      ctrl_o.led_select = led_sel_q;
      ctrl_o.trig_level = trig_level_q;
      ctrl_o.source_adc = source_adc_q;
      ctrl_o.arm_cmd    = arm_q;
   end

endmodule

//--- src/heartbeat_leds.sv
`timescale 1ns/1ps
`include "openadc_params.svh"

module heartbeat_leds #(
   parameter int TIMER_BITS = `OADC_TIMER_BITS
) (
   input  logic                           clk_usb,
   input  logic                           reset,
   input  logic [`OADC_LEDSEL_BITS-1:0]   led_select_i,
   input  openadc_pkg::oadc_status_t      status_i,
   output logic                           freq_measure_o,
   output logic                           led_armed_o,
   output logic                           led_capture_o
);

   logic [TIMER_BITS-1:0]  timer_q;
   logic                   meas_bit_r;
   logic                   flash_q;

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         timer_q        <= '0;
         meas_bit_r     <= 1'b0;
         freq_measure_o <= 1'b0;
      end else begin
         timer_q        <= timer_q + 1'b1;
         meas_bit_r     <= timer_q[TIMER_BITS-4];
         freq_measure_o <= timer_q[TIMER_BITS-4] && !meas_bit_r;   // rising edge
      end
   end

   // blinks only during the upper half of the timer period
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         flash_q <= 1'b0;
      end else if (timer_q[TIMER_BITS-1]) begin
         flash_q <= ~timer_q[TIMER_BITS-3];
      end
   end

   always_comb begin
      case (led_select_i)
         2'b00: begin
            led_armed_o   = status_i.armed;
            led_capture_o = status_i.trig_seen;
         end
         2'b01: begin
            led_armed_o   = timer_q[TIMER_BITS-2];
            led_capture_o = timer_q[TIMER_BITS-1];
         end
         default: begin
            led_armed_o   = flash_q;
            led_capture_o = flash_q;
         end
      endcase
   end

endmodule

//--- src/openadc_core.sv
`timescale 1ns/1ps
`include "openadc_params.svh"

module openadc_core #(
   parameter int TIMER_BITS = `OADC_TIMER_BITS
) (
   input  logic                        clk_usb,
   input  logic                        reset,
   input  openadc_pkg::axil_req_t      axil_req_i,
   input  logic [`OADC_ADC_BITS-1:0]   adc_data_i,
   output openadc_pkg::axil_rsp_t      axil_rsp_o,
   output logic                        amp_gain_o,
   output logic                        trigger_adc_o,
   output logic                        freq_measure_o,
   output logic                        led_armed_o,
   output logic                        led_capture_o
);

   openadc_pkg::oadc_ctrl_t    ctrl;     // register bank settings
   openadc_pkg::oadc_status_t  status;   // trigger state

   // register bank and gain pwm
   adc_reg_bank u_reg_bank (
      .clk_usb       (clk_usb),
      .reset         (reset),
      .axil_req_i    (axil_req_i),
      .status_i      (status),
      .axil_rsp_o    (axil_rsp_o),
      .ctrl_o        (ctrl),
      .amp_gain_o    (amp_gain_o)
   );

   adc_level_trigger u_level_trigger (
      .clk_usb       (clk_usb),
      .reset         (reset),
      .ctrl_i        (ctrl),
      .adc_data_i    (adc_data_i),
      .status_o      (status),
      .trigger_adc_o (trigger_adc_o)
   );

   heartbeat_leds #(
      .TIMER_BITS    (TIMER_BITS)
   ) u_heartbeat (
      .clk_usb        (clk_usb),
      .reset          (reset),
      .led_select_i   (ctrl.led_select),
      .status_i       (status),
      .freq_measure_o (freq_measure_o),
      .led_armed_o    (led_armed_o),
      .led_capture_o  (led_capture_o)
   );

endmodule

//--- src/openadc_params.svh
`ifndef OPENADC_PARAMS_SVH
`define OPENADC_PARAMS_SVH

// register map, byte offsets
`define OADC_REG_GAIN        8'h00
`define OADC_REG_LEDSEL      8'h04
`define OADC_REG_TRIGLVL     8'h08
`define OADC_REG_CTRL        8'h0C
`define OADC_REG_STATUS      8'h10  // read only

// bit positions inside ctrl and status words
`define OADC_CTRL_SRC_BIT    0      // 1 = adc input, 0 = test counter
`define OADC_CTRL_ARM_BIT    1      // write one to arm, not stored
`define OADC_STAT_ARMED_BIT  0
`define OADC_STAT_SEEN_BIT   1

// field widths
`define OADC_ADC_BITS        12
`define OADC_GAIN_BITS       8
`define OADC_LEDSEL_BITS     2

// heartbeat timer width, 2^26 cycles for a full led period
`define OADC_TIMER_BITS      26

// axi4-lite bus
`define OADC_AXI_ADDR_BITS   8
`define OADC_AXI_DATA_BITS   32
`define OADC_AXI_RESP_OKAY   2'b00

`endif

//--- src/openadc_pkg.sv
`include "openadc_params.svh"

package openadc_pkg;

   // master side of the register bus
   typedef struct packed {
      logic                               awvalid;
      logic [`OADC_AXI_ADDR_BITS-1:0]     awaddr;
      logic                               wvalid;
      logic [`OADC_AXI_DATA_BITS-1:0]     wdata;
      logic [`OADC_AXI_DATA_BITS/8-1:0]   wstrb;    // full words only
      logic                               bready;
      logic                               arvalid;
      logic [`OADC_AXI_ADDR_BITS-1:0]     araddr;
      logic                               rready;
   } axil_req_t;

   // slave side of the register bus
   typedef struct packed {
      logic                               awready;
      logic                               wready;
      logic                               bvalid;
      logic [1:0]                         bresp;
      logic                               arready;
      logic                               rvalid;
      logic [`OADC_AXI_DATA_BITS-1:0]     rdata;
      logic [1:0]                         rresp;
   } axil_rsp_t;

   // settings from the register bank
   typedef struct packed {
      logic [`OADC_LEDSEL_BITS-1:0]       led_select;
      logic [`OADC_ADC_BITS-1:0]          trig_level;  // msb also picks direction
      logic                               source_adc;
      logic                               arm_cmd;     // one cycle pulse
   } oadc_ctrl_t;

   // trigger state going back out
   typedef struct packed {
      logic                               armed;
      logic                               trig_seen;   // sticky until next arm
   } oadc_status_t;

endpackage

//--- test/openadc_sva.sv
`timescale 1ns/1ps

module openadc_sva (
   input logic                        clk_usb,
   input logic                        reset,
   input openadc_pkg::axil_req_t      req_i,
   input openadc_pkg::axil_rsp_t      rsp_i,
   input logic                        trigger_i,
   input openadc_pkg::oadc_status_t   status_i
);

   // responses wait for the master
   bvalid_hold: assert property (@(posedge clk_usb) disable iff (reset)
      rsp_i.bvalid && !req_i.bready |=> rsp_i.bvalid)
      else $error("bvalid dropped before bready");

   rvalid_hold: assert property (@(posedge clk_usb) disable iff (reset)
      rsp_i.rvalid && !req_i.rready |=> rsp_i.rvalid)
      else $error("rvalid dropped before rready");

   rdata_stable: assert property (@(posedge clk_usb) disable iff (reset)
      rsp_i.rvalid && !req_i.rready |=> $stable(rsp_i.rdata))
      else $error("rdata changed while waiting for rready");

   trigger_single: assert property (@(posedge clk_usb) disable iff (reset)
      trigger_i |=> !trigger_i)
      else $error("trigger pulse longer than one cycle");

   disarm_after_trigger: assert property (@(posedge clk_usb) disable iff (reset)
      trigger_i |=> !status_i.armed)
      else $error("still armed after a trigger pulse");

endmodule

bind openadc_core openadc_sva sva0 (
   .clk_usb   (clk_usb),
   .reset     (reset),
   .req_i     (axil_req_i),
   .rsp_i     (axil_rsp_o),
   .trigger_i (trigger_adc_o),
   .status_i  (status)
);

//--- test/openadc_tb.sv
`timescale 1ns/1ps
`include "openadc_params.svh"

module openadc_tb;

   localparam int TB_TIMER_BITS  = 10;
   localparam int TEST_CYCLES    = 5000;               // typical length of all five tests
   localparam int TIMEOUT_CYCLES = 4 * TEST_CYCLES;

   logic                            clk_usb;
   logic                            reset;
   openadc_pkg::axil_req_t          req;
   openadc_pkg::axil_rsp_t          rsp;
   logic [`OADC_ADC_BITS-1:0]       adc_data;
   logic                            amp_gain;
   logic                            trigger_adc;
   logic                            freq_measure;
   logic                            led_armed;
   logic                            led_capture;
   int                              cyc = 0;             // edges since reset release
   int                              errors = 0;
   int                              checks = 0;
   int                              trig_count = 0;
   logic [15:0]                     lfsr = 16'd7;

   openadc_core #(.TIMER_BITS(TB_TIMER_BITS)) dut0 (
      .clk_usb        (clk_usb),
      .reset          (reset),
      .axil_req_i     (req),
      .adc_data_i     (adc_data),
      .axil_rsp_o     (rsp),
      .amp_gain_o     (amp_gain),
      .trigger_adc_o  (trigger_adc),
      .freq_measure_o (freq_measure),
      .led_armed_o    (led_armed),
      .led_capture_o  (led_capture)
   );

   initial begin
      clk_usb = 1'b0;
      forever #20 clk_usb = ~clk_usb;
   end

   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   // one lfsr step per bit
   task automatic rand_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         v = {v[30:0], lfsr[0]};
      end
   endtask

   function automatic logic [31:0] reg_mask(input logic [7:0] addr);
      case (addr)
         `OADC_REG_GAIN:    return 32'h0000_00FF;
         `OADC_REG_LEDSEL:  return 32'h0000_0003;
         `OADC_REG_TRIGLVL: return 32'h0000_0FFF;
         `OADC_REG_CTRL:    return 32'h0000_0001;   // arm bit reads back zero
         default:           return 32'h0;
      endcase
   endfunction

   function automatic int pwm_high_count(input logic [7:0] gain);
      return int'(gain);   // carries per 256 cycles
   endfunction

   function automatic logic level_hit_ref(input logic [11:0] sample, input logic [11:0] level);
      if (level[11]) begin
         return sample > level;
      end
      return sample < level;
   endfunction

   function automatic logic [TB_TIMER_BITS-1:0] timer_ref(input int k);
      if (k < 0) begin
         return '0;
      end
      return k[TB_TIMER_BITS-1:0];
   endfunction

   // pulse one cycle after the measure bit rises
   function automatic logic freq_ref(input int k);
      logic [TB_TIMER_BITS-1:0] t1;
      logic [TB_TIMER_BITS-1:0] t2;
      t1 = timer_ref(k - 1);
      t2 = timer_ref(k - 2);
      return t1[TB_TIMER_BITS-4] && !t2[TB_TIMER_BITS-4];
   endfunction

   // last value loaded while the timer msb was set, zero before that
   function automatic logic flash_ref(input int k);
      logic [TB_TIMER_BITS-1:0] t;
      for (int j = k - 1; j >= 0; j--) begin
         t = timer_ref(j);
         if (t[TB_TIMER_BITS-1]) begin
            return ~t[TB_TIMER_BITS-3];
         end
      end
      return 1'b0;
   endfunction

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
      end
   endtask

   task automatic tick();
      @(posedge clk_usb);
      #2;
   endtask

   task automatic axi_write(input logic [7:0] addr, input logic [31:0] data);
      logic [31:0] r;
      logic        done;
      req.awvalid = 1'b1;
      req.awaddr  = addr;
      req.wvalid  = 1'b1;
      req.wdata   = data;
      req.wstrb   = 4'hF;
      done = 1'b0;
      while (!done) begin
         @(negedge clk_usb);
         done = rsp.awready && rsp.wready;
         tick();
      end
      req.awvalid = 1'b0;
      req.wvalid  = 1'b0;
      done = 1'b0;
      while (!done) begin
         rand_bits(1, r);
         req.bready = r[0];   // random back-pressure
         @(negedge clk_usb);
         done = rsp.bvalid && req.bready;
         if (done) check("bresp", rsp.bresp, `OADC_AXI_RESP_OKAY);
         tick();
      end
      req.bready = 1'b0;
   endtask

   task automatic axi_read(input logic [7:0] addr, output logic [31:0] data);
      logic [31:0] r;
      logic        done;
      req.arvalid = 1'b1;
      req.araddr  = addr;
      done = 1'b0;
      while (!done) begin
         @(negedge clk_usb);
         done = rsp.arready;
         tick();
      end
      req.arvalid = 1'b0;
      done = 1'b0;
      while (!done) begin
         rand_bits(1, r);
         req.rready = r[0];
         @(negedge clk_usb);
         done = rsp.rvalid && req.rready;
         data = rsp.rdata;
         if (done) check("rresp", rsp.rresp, `OADC_AXI_RESP_OKAY);
         tick();
      end
      req.rready = 1'b0;
   endtask

   always @(posedge clk_usb) begin
      if (!reset) begin
         cyc <= cyc + 1;
         if (cyc >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("test failed");
            $finish;
         end
      end
   end

   // heartbeat pulse compared against the reference timer all run long
   always @(negedge clk_usb) begin
      if (!reset && cyc > 0) begin
         check("freq_measure_o", freq_measure, freq_ref(cyc));
      end
      if (trigger_adc) trig_count++;
   end

   initial begin
      logic [31:0] v;
      logic [31:0] rd;
      logic [7:0]  addrs [4];
      logic [7:0]  gains [5];
      logic        hit;
      int          cnt;
      int          n;
      req      = '0;
      adc_data = '0;
      reset    = 1'b1;
      repeat (8) @(posedge clk_usb);
      #2;
      reset = 1'b0;
      tick();

      // register access
      addrs = '{`OADC_REG_GAIN, `OADC_REG_LEDSEL, `OADC_REG_TRIGLVL, `OADC_REG_CTRL};
      foreach (addrs[i]) begin
         rand_bits(32, v);
         if (addrs[i] == `OADC_REG_CTRL) v[`OADC_CTRL_ARM_BIT] = 1'b0;
         axi_write(addrs[i], v);
         axi_read(addrs[i], rd);
         check($sformatf("rdata at 0x%0h", addrs[i]), rd, v & reg_mask(addrs[i]));
      end
      rand_bits(32, v);
      axi_write(8'h14, v);
      axi_read(8'h14, rd);
      check("rdata at 0x14", rd, 32'h0);
      axi_read(8'hFC, rd);
      check("rdata at 0xfc", rd, 32'h0);

      // gain pwm
      rand_bits(8, v);
      gains = '{8'h00, 8'h01, 8'h80, 8'hFF, v[7:0]};
      foreach (gains[i]) begin
         axi_write(`OADC_REG_GAIN, {24'h0, gains[i]});
         cnt = 0;
         repeat (256) begin
            @(negedge clk_usb);
            if (amp_gain) cnt++;
            tick();
         end
         check("amp_gain_o high count", cnt, pwm_high_count(gains[i]));
      end

      // level trigger on the adc input
      axi_write(`OADC_REG_CTRL, 32'h1);
      repeat (8) begin
         rand_bits(12, v);
         adc_data = v[11:0];
         rand_bits(12, rd);
         axi_write(`OADC_REG_TRIGLVL, rd);
         repeat (4) tick();   // let any leftover shot fire
         hit = level_hit_ref(v[11:0], rd[11:0]);
         trig_count = 0;
         axi_write(`OADC_REG_CTRL, 32'h3);
         repeat (10) tick();
         check("trigger_adc_o pulses", trig_count, hit);
         axi_read(`OADC_REG_STATUS, rd);
         check("status", rd, hit ? 32'h2 : 32'h1);
      end

      // flush an arm left pending by a miss
      adc_data = 12'hFFF;
      axi_write(`OADC_REG_TRIGLVL, 32'h800);
      repeat (6) tick();

      // counter source, one pulse per arm
      rand_bits(8, v);
      axi_write(`OADC_REG_TRIGLVL, 32'h800 | v[7:0]);
      axi_write(`OADC_REG_CTRL, 32'h0);
      repeat (3) begin
         trig_count = 0;
         axi_write(`OADC_REG_CTRL, 32'h2);
         n = 0;
         while (trig_count == 0 && n < 4200) begin
            tick();
            n++;
         end
         if (trig_count == 0) begin
            errors++;
            $display("no trigger pulse from the counter source after arming");
         end
         repeat (50) tick();
         check("trigger_adc_o pulses per arm", trig_count, 1);
         axi_read(`OADC_REG_STATUS, rd);
         check("status", rd, 32'h2);
      end

      // heartbeat leds
      axi_write(`OADC_REG_LEDSEL, 32'h1);
      repeat (1100) begin
         @(negedge clk_usb);
         v = timer_ref(cyc);
         check("led_armed_o", led_armed, v[TB_TIMER_BITS-2]);
         check("led_capture_o", led_capture, v[TB_TIMER_BITS-1]);
         tick();
      end
      axi_write(`OADC_REG_LEDSEL, 32'h2);
      repeat (1100) begin
         @(negedge clk_usb);
         check("led_armed_o", led_armed, flash_ref(cyc));
         check("led_capture_o", led_capture, flash_ref(cyc));
         tick();
      end
      axi_write(`OADC_REG_LEDSEL, 32'h0);
      axi_read(`OADC_REG_STATUS, rd);
      check("status", rd, 32'h2);   // disarmed, shot seen
      @(negedge clk_usb);
      check("led_armed_o", led_armed, rd[`OADC_STAT_ARMED_BIT]);
      check("led_capture_o", led_capture, rd[`OADC_STAT_SEEN_BIT]);
      tick();

      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule
